// ==== verilog/memAccessPkg.sv ====
package memAccessPkg;

    // Width of the access type field from execute
    localparam int AccessTypeWidth = 3;

    localparam int DataWidth = 32;
    localparam int HiLoWidth = 64;
    localparam int RegAddrWidth = 7;

    // Byte lanes in one data word
    localparam int LaneCount = 4;

    // Low two bits of the access type; code 2'b11 means no memory access
    typedef enum logic [1:0] {
        sizeByte = 2'b00,
        sizeHalf = 2'b01,
        sizeWord = 2'b10
    } accessSizeT;

endpackage

// ==== verilog/memAccessDecode.sv ====
`timescale 1ns/1ps

module memAccessDecode import memAccessPkg::*; (
    input  logic [AccessTypeWidth-1:0] accessType,
    input  logic [1:0]                 addrLow,
    output accessSizeT                 accessSize,
    output logic                       loadUnsigned,
    output logic [LaneCount-1:0]       laneMask,
    output logic                       misaligned
);

    assign accessSize   = accessSizeT'(accessType[1:0]);
    assign loadUnsigned = accessType[2];

    // Lane mask and alignment check from size and byte offset
    always_comb
    begin
        laneMask   = '0;
        misaligned = 1'b0;
        case (accessSize)
            sizeByte:
            begin
                laneMask = LaneCount'(1) << addrLow;
            end
            sizeHalf:
            begin
                if (addrLow[0])
                begin
                    misaligned = 1'b1;
                end
                else
                begin
                    // Offset is 0 or 2 here, so the pair lands on lanes 0-1 or 2-3
                    laneMask = LaneCount'(2'b11) << addrLow;
                end
            end
            sizeWord:
            begin
                if (addrLow != 2'b00)
                begin
                    misaligned = 1'b1;
                end
                else
                begin
                    laneMask = '1;
                end
            end
            default:
            begin
                laneMask = '0;
            end
        endcase
    end

endmodule

// ==== verilog/storeAlign.sv ====
`timescale 1ns/1ps

module storeAlign import memAccessPkg::*; (
    input  logic [LaneCount-1:0] laneMask,
    input  logic                 memWrite,
    input  logic [DataWidth-1:0] storeData,
    output logic [LaneCount-1:0] byteWe,
    output logic [DataWidth-1:0] ramWriteData
);

    localparam int ByteWidth = DataWidth / LaneCount;
    localparam int HalfWidth = 2 * ByteWidth;

    logic [DataWidth-1:0] replicated;
    logic [DataWidth-1:0] laneBits;

    assign byteWe = memWrite ? laneMask : '0;

    // The number of set lanes tells byte, halfword or word apart
    always_comb
    begin
        case (laneMask)
            4'b1111:
            begin
                replicated = storeData;
            end
            4'b0011, 4'b1100:
            begin
                replicated = {(LaneCount / 2){storeData[HalfWidth-1:0]}};
            end
            default:
            begin
                replicated = {LaneCount{storeData[ByteWidth-1:0]}};
            end
        endcase
    end

    // Expand each lane bit over its byte so unselected lanes stay zero
    always_comb
    begin
        for (int i = 0; i < LaneCount; i++)
        begin
            laneBits[ByteWidth*i +: ByteWidth] = {ByteWidth{laneMask[i]}};
        end
    end

    assign ramWriteData = replicated & laneBits;

endmodule

// ==== verilog/dataRam.sv ====
`timescale 1ns/1ps

module dataRam import memAccessPkg::*; #(
    parameter int addrWidth = 10
) (
    input  logic                 clk,
    input  logic [addrWidth-1:0] wordAddr,
    input  logic [LaneCount-1:0] byteWe,
    input  logic [DataWidth-1:0] writeData,
    input  logic                 readEnable,
    output logic [DataWidth-1:0] readData
);

    localparam int Depth     = 1 << addrWidth;
    localparam int ByteWidth = DataWidth / LaneCount;

    logic [DataWidth-1:0] mem [Depth];
    logic [DataWidth-1:0] mergedWord;

    // Current word with this cycle's write lanes already applied
    always_comb
    begin
        mergedWord = mem[wordAddr];
        for (int i = 0; i < LaneCount; i++)
        begin
            if (byteWe[i])
            begin
                mergedWord[ByteWidth*i +: ByteWidth] = writeData[ByteWidth*i +: ByteWidth];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < LaneCount; i++)
        begin
            if (byteWe[i])
            begin
                mem[wordAddr][ByteWidth*i +: ByteWidth] <= writeData[ByteWidth*i +: ByteWidth];
            end
        end
        // Write-first, so a read in the same cycle returns the new data
        if (readEnable)
        begin
            readData <= mergedWord;
        end
    end

endmodule

// ==== verilog/memWbReg.sv ====
`timescale 1ns/1ps

module memWbReg import memAccessPkg::*; (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    regWrite,
    input  logic                    memToReg,
    input  logic [RegAddrWidth-1:0] writeRegister,
    input  logic [DataWidth-1:0]    aluOut,
    input  logic [DataWidth-1:0]    pcIn,
    input  logic                    hiLoWriteEnable,
    input  logic [HiLoWidth-1:0]    hiLoData,
    input  accessSizeT              accessSize,
    input  logic                    loadUnsigned,
    input  logic                    misaligned,
    output logic                    regWriteW,
    output logic                    memToRegW,
    output logic [RegAddrWidth-1:0] writeRegisterW,
    output logic [DataWidth-1:0]    aluOutW,
    output logic [DataWidth-1:0]    pcOut,
    output logic                    hiLoWriteEnableW,
    output logic [HiLoWidth-1:0]    hiLoDataW,
    output accessSizeT              accessSizeW,
    output logic                    loadUnsignedW,
    output logic                    addrErrorW
);

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            regWriteW        <= 1'b0;
            memToRegW        <= 1'b0;
            writeRegisterW   <= '0;
            aluOutW          <= '0;
            pcOut            <= '0;
            hiLoWriteEnableW <= 1'b0;
            hiLoDataW        <= '0;
            accessSizeW      <= sizeByte;
            loadUnsignedW    <= 1'b0;
            addrErrorW       <= 1'b0;
        end
        else
        begin
            // A misaligned access must not reach the register file
            regWriteW        <= regWrite & ~misaligned;
            memToRegW        <= memToReg;
            writeRegisterW   <= writeRegister;
            aluOutW          <= aluOut;
            pcOut            <= pcIn;
            hiLoWriteEnableW <= hiLoWriteEnable;
            hiLoDataW        <= hiLoData;
            accessSizeW      <= accessSize;
            loadUnsignedW    <= loadUnsigned;
            addrErrorW       <= misaligned;
        end
    end

endmodule

// ==== verilog/loadResult.sv ====
`timescale 1ns/1ps

module loadResult import memAccessPkg::*; (
    input  logic [DataWidth-1:0] readData,
    input  accessSizeT           accessSize,
    input  logic                 loadUnsigned,
    input  logic [1:0]           addrLow,
    input  logic                 memToReg,
    input  logic [DataWidth-1:0] aluOut,
    output logic [DataWidth-1:0] result
);

    localparam int ByteWidth = DataWidth / LaneCount;
    localparam int HalfWidth = 2 * ByteWidth;

    logic [ByteWidth-1:0] laneByte;
    logic [HalfWidth-1:0] laneHalf;
    logic                 signBit;
    logic [DataWidth-1:0] loadValue;

    // Offset picks the lane; a halfword offset is 0 or 2 once aligned
    assign laneByte = readData[ByteWidth*addrLow +: ByteWidth];
    assign laneHalf = addrLow[1] ? readData[DataWidth-1 -: HalfWidth]
                                 : readData[HalfWidth-1:0];

    always_comb
    begin
        signBit   = 1'b0;
        loadValue = readData;
        case (accessSize)
            sizeByte:
            begin
                signBit   = ~loadUnsigned & laneByte[ByteWidth-1];
                loadValue = {{(DataWidth - ByteWidth){signBit}}, laneByte};
            end
            sizeHalf:
            begin
                signBit   = ~loadUnsigned & laneHalf[HalfWidth-1];
                loadValue = {{(DataWidth - HalfWidth){signBit}}, laneHalf};
            end
            default:
            begin
                loadValue = readData;
            end
        endcase
    end

    assign result = memToReg ? loadValue : aluOut;

endmodule

// ==== verilog/memStage.sv ====
`timescale 1ns/1ps

module memStage import memAccessPkg::*; #(
    parameter int RamAddrWidth = 10
) (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic [AccessTypeWidth-1:0] accessType,
    input  logic                       memRead,
    input  logic                       memWrite,
    input  logic                       memToReg,
    input  logic                       regWrite,
    input  logic [DataWidth-1:0]       aluOut,
    input  logic [DataWidth-1:0]       storeData,
    input  logic [RegAddrWidth-1:0]    writeRegister,
    input  logic [DataWidth-1:0]       pcIn,
    input  logic                       hiLoWriteEnable,
    input  logic [HiLoWidth-1:0]       hiLoData,
    output logic                       regWriteW,
    output logic                       memToRegW,
    output logic [RegAddrWidth-1:0]    writeRegisterW,
    output logic [DataWidth-1:0]       aluOutW,
    output logic [DataWidth-1:0]       pcOut,
    output logic                       hiLoWriteEnableW,
    output logic [HiLoWidth-1:0]       hiLoDataW,
    output logic                       addrErrorW,
    output logic [DataWidth-1:0]       resultW
);

    accessSizeT           accessSize;
    logic                 loadUnsigned;
    logic [LaneCount-1:0] laneMask;
    logic                 misaligned;
    logic [LaneCount-1:0] byteWe;
    logic [DataWidth-1:0] ramWriteData;
    logic [DataWidth-1:0] readData;
    accessSizeT           accessSizeW;
    logic                 loadUnsignedW;

    memAccessDecode decodeInst (
        .accessType   (accessType),
        .addrLow      (aluOut[1:0]),
        .accessSize   (accessSize),
        .loadUnsigned (loadUnsigned),
        .laneMask     (laneMask),
        .misaligned   (misaligned)
    );

    storeAlign storeAlignInst (
        .laneMask     (laneMask),
        .memWrite     (memWrite),
        .storeData    (storeData),
        .byteWe       (byteWe),
        .ramWriteData (ramWriteData)
    );

    // Word address sits above the two byte offset bits
    dataRam #(
        .addrWidth (RamAddrWidth)
    ) ramInst (
        .clk        (clk),
        .wordAddr   (aluOut[RamAddrWidth+1:2]),
        .byteWe     (byteWe),
        .writeData  (ramWriteData),
        .readEnable (memRead),
        .readData   (readData)
    );

    memWbReg memWbInst (
        .clk              (clk),
        .rstN             (rstN),
        .regWrite         (regWrite),
        .memToReg         (memToReg),
        .writeRegister    (writeRegister),
        .aluOut           (aluOut),
        .pcIn             (pcIn),
        .hiLoWriteEnable  (hiLoWriteEnable),
        .hiLoData         (hiLoData),
        .accessSize       (accessSize),
        .loadUnsigned     (loadUnsigned),
        .misaligned       (misaligned),
        .regWriteW        (regWriteW),
        .memToRegW        (memToRegW),
        .writeRegisterW   (writeRegisterW),
        .aluOutW          (aluOutW),
        .pcOut            (pcOut),
        .hiLoWriteEnableW (hiLoWriteEnableW),
        .hiLoDataW        (hiLoDataW),
        .accessSizeW      (accessSizeW),
        .loadUnsignedW    (loadUnsignedW),
        .addrErrorW       (addrErrorW)
    );

    loadResult loadResultInst (
        .readData     (readData),
        .accessSize   (accessSizeW),
        .loadUnsigned (loadUnsignedW),
        .addrLow      (aluOutW[1:0]),
        .memToReg     (memToRegW),
        .aluOut       (aluOutW),
        .result       (resultW)
    );

endmodule

// ==== test/memStage_checker.sv ====
`timescale 1ns/1ps

module memStage_checker import memAccessPkg::*; (
    input logic                 clk,
    input logic                 rstN,
    input logic                 memWrite,
    input logic [LaneCount-1:0] byteWe,
    input logic                 regWriteW,
    input logic                 memToRegW,
    input logic                 hiLoWriteEnableW,
    input logic                 addrErrorW
);

    // High once reset was low at the previous edge, so the W flops have cleared
    logic resetHeld;

    always_ff @(posedge clk)
    begin
        resetHeld <= ~rstN;
    end

    assert property (@(posedge clk) disable iff (!rstN) !memWrite |-> byteWe == '0)
        else $error("byte enables active without a store");

    assert property (@(posedge clk) disable iff (!rstN)
        byteWe inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b1100, 4'b1111})
        else $error("illegal byte enable pattern %b", byteWe);

    assert property (@(posedge clk) (!rstN && resetHeld) |->
        (!regWriteW && !memToRegW && !hiLoWriteEnableW && !addrErrorW))
        else $error("writeback control high during reset");

endmodule

bind memStage memStage_checker checkerInst (
    .clk              (clk),
    .rstN             (rstN),
    .memWrite         (memWrite),
    .byteWe           (byteWe),
    .regWriteW        (regWriteW),
    .memToRegW        (memToRegW),
    .hiLoWriteEnableW (hiLoWriteEnableW),
    .addrErrorW       (addrErrorW)
);

// ==== test/memStageTb.sv ====
`timescale 1ns/1ps

module memStageTb import memAccessPkg::*; ();

    localparam int RamAddrWidth = 10;
    localparam int ResetCycles = 10;
    localparam int OpCount = 28;
    localparam int CycleLimit = 4 * OpCount + ResetCycles;
    localparam int ByteWidth = DataWidth / LaneCount;

    logic                       clk;
    logic                       rstN;
    logic [AccessTypeWidth-1:0] accessType;
    logic                       memRead;
    logic                       memWrite;
    logic                       memToReg;
    logic                       regWrite;
    logic [DataWidth-1:0]       aluOut;
    logic [DataWidth-1:0]       storeData;
    logic [RegAddrWidth-1:0]    writeRegister;
    logic [DataWidth-1:0]       pcIn;
    logic                       hiLoWriteEnable;
    logic [HiLoWidth-1:0]       hiLoData;
    logic                       regWriteW;
    logic                       memToRegW;
    logic [RegAddrWidth-1:0]    writeRegisterW;
    logic [DataWidth-1:0]       aluOutW;
    logic [DataWidth-1:0]       pcOut;
    logic                       hiLoWriteEnableW;
    logic [HiLoWidth-1:0]       hiLoDataW;
    logic                       addrErrorW;
    logic [DataWidth-1:0]       resultW;

    int errorCount = 0;
    int cycleCount = 0;

    // Byte-addressed model of the RAM, little-endian like the lane order
    logic [ByteWidth-1:0] modelMem [int];

    memStage #(
        .RamAddrWidth (RamAddrWidth)
    ) dut (
        .clk              (clk),
        .rstN             (rstN),
        .accessType       (accessType),
        .memRead          (memRead),
        .memWrite         (memWrite),
        .memToReg         (memToReg),
        .regWrite         (regWrite),
        .aluOut           (aluOut),
        .storeData        (storeData),
        .writeRegister    (writeRegister),
        .pcIn             (pcIn),
        .hiLoWriteEnable  (hiLoWriteEnable),
        .hiLoData         (hiLoData),
        .regWriteW        (regWriteW),
        .memToRegW        (memToRegW),
        .writeRegisterW   (writeRegisterW),
        .aluOutW          (aluOutW),
        .pcOut            (pcOut),
        .hiLoWriteEnableW (hiLoWriteEnableW),
        .hiLoDataW        (hiLoDataW),
        .addrErrorW       (addrErrorW),
        .resultW          (resultW)
    );

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit)
        begin
            $display("timeout: the tests did not finish within %0d cycles", CycleLimit);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic isMisaligned(input accessSizeT size, input logic [DataWidth-1:0] addr);
        return (size == sizeHalf && addr[0]) || (size == sizeWord && addr[1:0] != 2'b00);
    endfunction

    function automatic int sizeBytes(input accessSizeT size);
        return (size == sizeByte) ? 1 : (size == sizeHalf) ? 2 : 4;
    endfunction

    function automatic logic [DataWidth-1:0] randomWordAddr();
        logic [DataWidth-1:0] raw;
        raw = $urandom();
        raw[DataWidth-1:RamAddrWidth+2] = '0;
        raw[1:0] = 2'b00;
        return raw;
    endfunction

    function automatic void modelStore(input accessSizeT size, input logic [DataWidth-1:0] addr,
                                       input logic [DataWidth-1:0] data);
        int base;
        base = int'(addr[RamAddrWidth+1:0]);
        for (int i = 0; i < sizeBytes(size); i++)
        begin
            modelMem[base + i] = data[ByteWidth*i +: ByteWidth];
        end
    endfunction

    function automatic logic [DataWidth-1:0] modelLoad(input accessSizeT size, input logic isUnsigned,
                                                       input logic [DataWidth-1:0] addr);
        int base;
        int count;
        logic [DataWidth-1:0] value;
        logic signBit;
        base = int'(addr[RamAddrWidth+1:0]);
        count = sizeBytes(size);
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            value[ByteWidth*i +: ByteWidth] = modelMem[base + i];
        end
        signBit = ~isUnsigned & value[ByteWidth*count-1];
        for (int b = ByteWidth * count; b < DataWidth; b++)
        begin
            value[b] = signBit;
        end
        return value;
    endfunction

    task automatic reportMismatch(input string name, input logic [HiLoWidth-1:0] expected,
                                  input logic [HiLoWidth-1:0] actual);
        errorCount++;
        $display("error %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
    endtask

    task automatic checkData(input string name, input logic [DataWidth-1:0] expected,
                             input logic [DataWidth-1:0] actual);
        if (actual !== expected)
        begin
            reportMismatch(name, HiLoWidth'(expected), HiLoWidth'(actual));
        end
    endtask

    task automatic checkCtrl(input logic expRegWrite, input logic expMemToReg,
                             input logic [RegAddrWidth-1:0] expWriteRegister,
                             input logic expAddrError, input logic expHiLoWe,
                             input logic [HiLoWidth-1:0] expHiLoData);
        if (regWriteW !== expRegWrite)
            reportMismatch("regWriteW", HiLoWidth'(expRegWrite), HiLoWidth'(regWriteW));
        if (memToRegW !== expMemToReg)
            reportMismatch("memToRegW", HiLoWidth'(expMemToReg), HiLoWidth'(memToRegW));
        if (writeRegisterW !== expWriteRegister)
            reportMismatch("writeRegisterW", HiLoWidth'(expWriteRegister), HiLoWidth'(writeRegisterW));
        if (addrErrorW !== expAddrError)
            reportMismatch("addrErrorW", HiLoWidth'(expAddrError), HiLoWidth'(addrErrorW));
        if (hiLoWriteEnableW !== expHiLoWe)
            reportMismatch("hiLoWriteEnableW", HiLoWidth'(expHiLoWe), HiLoWidth'(hiLoWriteEnableW));
        if (hiLoDataW !== expHiLoData)
            reportMismatch("hiLoDataW", expHiLoData, hiLoDataW);
    endtask

    task automatic driveIdle();
        accessType <= {1'b0, 2'b11};
        memRead <= 1'b0;
        memWrite <= 1'b0;
        memToReg <= 1'b0;
        regWrite <= 1'b0;
        aluOut <= '0;
        storeData <= '0;
        writeRegister <= '0;
        pcIn <= '0;
        hiLoWriteEnable <= 1'b0;
        hiLoData <= '0;
    endtask

    // Every writeback field is non-zero while reset is held
    task automatic driveBusy();
        driveIdle();
        memToReg <= 1'b1;
        regWrite <= 1'b1;
        aluOut <= '1;
        writeRegister <= '1;
        pcIn <= '1;
        hiLoWriteEnable <= 1'b1;
        hiLoData <= '1;
    endtask

    task automatic driveOp(input logic isStore, input accessSizeT size, input logic isUnsigned,
                           input logic [DataWidth-1:0] addr, input logic [DataWidth-1:0] data,
                           input logic [RegAddrWidth-1:0] dest);
        accessType <= {isUnsigned, size};
        memRead <= ~isStore;
        memWrite <= isStore;
        memToReg <= ~isStore;
        regWrite <= ~isStore;
        aluOut <= addr;
        storeData <= data;
        writeRegister <= dest;
        pcIn <= '0;
        hiLoWriteEnable <= 1'b0;
        hiLoData <= '0;
    endtask

    task automatic storeOp(input accessSizeT size, input logic [DataWidth-1:0] addr,
                           input logic [DataWidth-1:0] data);
        logic bad;
        bad = isMisaligned(size, addr);
        @(posedge clk);
        driveOp(1'b1, size, 1'b0, addr, data, '0);
        @(posedge clk);
        driveIdle();
        if (!bad)
            modelStore(size, addr, data);
        @(negedge clk);
        checkCtrl(1'b0, 1'b0, '0, bad, 1'b0, '0);
        checkData("aluOutW", addr, aluOutW);
    endtask

    task automatic loadOp(input accessSizeT size, input logic isUnsigned,
                          input logic [DataWidth-1:0] addr);
        logic bad;
        logic [RegAddrWidth-1:0] dest;
        bad = isMisaligned(size, addr);
        dest = RegAddrWidth'($urandom());
        @(posedge clk);
        driveOp(1'b0, size, isUnsigned, addr, '0, dest);
        @(posedge clk);
        driveIdle();
        @(negedge clk);
        checkCtrl(~bad, 1'b1, dest, bad, 1'b0, '0);
        if (!bad)
            checkData("resultW", modelLoad(size, isUnsigned, addr), resultW);
    endtask

    task automatic resetTest();
        @(negedge clk);
        checkCtrl(1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
        checkData("resultW", '0, resultW);
        checkData("pcOut", '0, pcOut);
    endtask

    task automatic wordTest();
        logic [DataWidth-1:0] addr;
        addr = randomWordAddr();
        storeOp(sizeWord, addr, $urandom());
        loadOp(sizeWord, 1'b0, addr);
    endtask

    task automatic byteTest();
        logic [DataWidth-1:0] addr;
        logic [DataWidth-1:0] data;
        addr = randomWordAddr();
        // Alternate the byte sign bits so both extensions are exercised
        for (int lane = 0; lane < LaneCount; lane++)
        begin
            data = $urandom();
            data[ByteWidth-1] = lane[0];
            storeOp(sizeByte, addr + lane, data);
        end
        for (int lane = 0; lane < LaneCount; lane++)
        begin
            loadOp(sizeByte, 1'b0, addr + lane);
            loadOp(sizeByte, 1'b1, addr + lane);
        end
        loadOp(sizeWord, 1'b0, addr);
    endtask

    task automatic halfTest();
        logic [DataWidth-1:0] addr;
        logic [DataWidth-1:0] data;
        addr = randomWordAddr();
        data = $urandom();
        data[2*ByteWidth-1] = 1'b1;
        storeOp(sizeHalf, addr, data);
        data = $urandom();
        data[2*ByteWidth-1] = 1'b0;
        storeOp(sizeHalf, addr + 2, data);
        for (int offset = 0; offset < LaneCount; offset += 2)
        begin
            loadOp(sizeHalf, 1'b0, addr + offset);
            loadOp(sizeHalf, 1'b1, addr + offset);
        end
        // Misaligned store and load, then confirm the word kept its contents
        storeOp(sizeHalf, addr + 1, $urandom());
        loadOp(sizeWord, 1'b0, addr + 2);
        loadOp(sizeWord, 1'b0, addr);
    endtask

    task automatic passThroughTest();
        logic [DataWidth-1:0] value;
        logic [DataWidth-1:0] pc;
        logic [HiLoWidth-1:0] hiLo;
        logic [RegAddrWidth-1:0] dest;
        for (int i = 0; i < 2; i++)
        begin
            value = $urandom();
            pc = $urandom();
            hiLo = {$urandom(), $urandom()};
            dest = RegAddrWidth'($urandom());
            @(posedge clk);
            driveIdle();
            regWrite <= 1'b1;
            aluOut <= value;
            writeRegister <= dest;
            pcIn <= pc;
            hiLoWriteEnable <= i[0];
            hiLoData <= hiLo;
            @(posedge clk);
            driveIdle();
            @(negedge clk);
            checkCtrl(1'b1, 1'b0, dest, 1'b0, i[0], hiLo);
            checkData("resultW", value, resultW);
            checkData("aluOutW", value, aluOutW);
            checkData("pcOut", pc, pcOut);
        end
    endtask

    task automatic backToBackTest();
        logic [DataWidth-1:0] addr;
        logic [DataWidth-1:0] data;
        logic [RegAddrWidth-1:0] dest;
        addr = randomWordAddr();
        data = $urandom();
        dest = RegAddrWidth'($urandom());
        @(posedge clk);
        driveOp(1'b1, sizeWord, 1'b0, addr, data, '0);
        @(posedge clk);
        driveOp(1'b0, sizeWord, 1'b0, addr, '0, dest);
        modelStore(sizeWord, addr, data);
        @(negedge clk);
        checkCtrl(1'b0, 1'b0, '0, 1'b0, 1'b0, '0);
        @(posedge clk);
        driveIdle();
        @(negedge clk);
        checkCtrl(1'b1, 1'b1, dest, 1'b0, 1'b0, '0);
        checkData("resultW", data, resultW);
    endtask

    initial
    begin
        void'($urandom(68042));
        clk = 1'b0;
        rstN = 1'b0;
        driveBusy();
        repeat (ResetCycles) @(posedge clk);
        rstN <= 1'b1;
        driveIdle();
        resetTest();
        wordTest();
        byteTest();
        halfTest();
        passThroughTest();
        backToBackTest();
        repeat (2) @(posedge clk);
        $display("errors: %0d", errorCount);
        if (errorCount == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== memStage.f ====
verilog/memAccessPkg.sv
verilog/memAccessDecode.sv
verilog/storeAlign.sv
verilog/dataRam.sv
verilog/memWbReg.sv
verilog/loadResult.sv
verilog/memStage.sv
test/memStage_checker.sv
test/memStageTb.sv

// ==== Makefile ====
# Verilator build for the MEM stage testbench

VERILATOR ?= verilator
TOP       ?= memStageTb
FILELIST  ?= memStage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= -sv --timing --assert
PASS_TEXT ?= Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
